// File: flist.f
hdl/ooo_cfg_pkg.sv
hdl/rv32i_types.sv
hdl/inst_queue.sv
hdl/free_list.sv
hdl/rat.sv
hdl/rename_dispatch.sv
hdl/rename_top.sv
verif/rename_asserts.sv
verif/rename_tb.sv

// File: Bender.yml
package:
  name: rename_front

sources:
  - hdl/ooo_cfg_pkg.sv
  - hdl/rv32i_types.sv
  - hdl/inst_queue.sv
  - hdl/free_list.sv
  - hdl/rat.sv
  - hdl/rename_dispatch.sv
  - hdl/rename_top.sv
  - target: test
    files:
      - verif/rename_asserts.sv
      - verif/rename_tb.sv

// File: verif/rename_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rename_tb;
    import ooo_cfg_pkg::*;
    import rv32i_types::*;

    localparam int NUM_ROWS = 14;
    // exhaustion and queue-full scenarios add roughly this many rows
    localparam int EXTRA_ROWS = 40;
    localparam int CYCLE_LIMIT = 40 * (NUM_ROWS + EXTRA_ROWS);

    // stall bits in order rob, alu, mul, div, br, mem
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [5:0]  stall;
        rs_sel_e     sel;
        logic [31:0] imm;
        arch_reg_t   rd;
        logic        need;
    } row_t;

    logic clk;
    logic rst;
    logic push;
    logic [31:0] inst;
    logic [31:0] pc;
    logic iq_full;
    logic rob_full;
    logic rs_full_alu;
    logic rs_full_mul;
    logic rs_full_div;
    logic rs_full_br;
    logic rs_full_mem;
    logic release_valid;
    phys_reg_t release_preg;
    logic cdb_valid;
    phys_reg_t cdb_preg;
    logic dispatch;
    rs_sel_e rs_sel;
    opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    arch_reg_t rd_s;
    arch_reg_t rs1_s;
    arch_reg_t rs2_s;
    logic [31:0] imm;
    logic [31:0] pc_out;
    logic [31:0] pc_next;
    phys_reg_t pd;
    phys_reg_t ps1;
    phys_reg_t ps2;
    logic ps1_ready;
    logic ps2_ready;

    // reference model state
    phys_reg_t map_m [ARCH_REGS];
    logic ready_m [ARCH_REGS];
    phys_reg_t fl_q [$];
    row_t iq_q [$];
    row_t table_rows [NUM_ROWS];
    logic [31:0] lcg_state;
    logic [31:0] next_pc;
    int cycles;

    rename_top UUT (
        .clk(clk), .rst(rst), .push(push), .inst(inst), .pc(pc), .iq_full(iq_full),
        .rob_full(rob_full), .rs_full_alu(rs_full_alu), .rs_full_mul(rs_full_mul),
        .rs_full_div(rs_full_div), .rs_full_br(rs_full_br), .rs_full_mem(rs_full_mem),
        .release_valid(release_valid), .release_preg(release_preg),
        .cdb_valid(cdb_valid), .cdb_preg(cdb_preg),
        .dispatch(dispatch), .rs_sel(rs_sel), .opcode(opcode),
        .funct3(funct3), .funct7(funct7), .rd_s(rd_s), .rs1_s(rs1_s), .rs2_s(rs2_s),
        .imm(imm), .pc_out(pc_out), .pc_next(pc_next), .pd(pd), .ps1(ps1), .ps2(ps2),
        .ps1_ready(ps1_ready), .ps2_ready(ps2_ready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (!rst) begin
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                $display("timeout: run exceeded %0d cycles without finishing", CYCLE_LIMIT);
                $display("=== FAIL ===");
                $fatal(1, "timeout");
            end
        end
    end

    // stop at the first failure of the bound checker
    always @(negedge clk) begin
        if (UUT.u_asserts.fail_count != 0) begin
            $display("a bound assertion on dispatch or allocation failed");
            $display("=== FAIL ===");
            $fatal(1, "assertion failure");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic row_t make_row(input logic [31:0] i, input rs_sel_e sel,
                                      input logic [31:0] im, input arch_reg_t rd,
                                      input logic need);
        row_t r;
        r = '{i, next_pc, 6'b0, sel, im, rd, need};
        next_pc = next_pc + 32'd4;
        return r;
    endfunction

    // true when rob or the row's own station is full
    function automatic logic class_stalled(input rs_sel_e sel);
        case (sel)
            RS_ALU:  return rob_full || rs_full_alu;
            RS_MUL:  return rob_full || rs_full_mul;
            RS_DIV:  return rob_full || rs_full_div;
            RS_BR:   return rob_full || rs_full_br;
            default: return rob_full || rs_full_mem;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_preg(input string name, input phys_reg_t exp, input phys_reg_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "preg mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_rs_sel(input string name, input rs_sel_e exp, input rs_sel_e act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %s actual %s", name, exp.name(), act.name());
            $display("=== FAIL ===");
            $fatal(1, "class mismatch");
        end
    endtask

    // outputs are stable at the falling edge; model then steps to the next edge
    task automatic check_and_update(input logic do_push, input row_t r);
        row_t h;
        logic exp_disp;
        logic accepted;
        string tag;
        arch_reg_t a1;
        arch_reg_t a2;
        arch_reg_t ad;
        exp_disp = 1'b0;
        accepted = do_push && (iq_q.size() < IQ_DEPTH);
        check_flag("iq_full", iq_q.size() == IQ_DEPTH, iq_full);
        if (iq_q.size() == 0) begin
            check_flag("idle dispatch", 1'b0, dispatch);
        end else begin
            h = iq_q[0];
            a1 = h.inst[19:15];
            a2 = h.inst[24:20];
            ad = h.rd;
            tag = $sformatf("pc %h", h.pc);
            exp_disp = !class_stalled(h.sel) && (!h.need || fl_q.size() > 0);
            check_flag({tag, " dispatch"}, exp_disp, dispatch);
            check_rs_sel({tag, " rs_sel"}, h.sel, rs_sel);
            check_word({tag, " opcode"}, {25'b0, h.inst[6:0]}, {25'b0, opcode});
            check_word({tag, " funct3"}, {29'b0, h.inst[14:12]}, {29'b0, funct3});
            check_word({tag, " funct7"}, {25'b0, h.inst[31:25]}, {25'b0, funct7});
            check_word({tag, " imm"}, h.imm, imm);
            check_word({tag, " rd_s"}, {27'b0, ad}, {27'b0, rd_s});
            check_word({tag, " rs1_s"}, {27'b0, a1}, {27'b0, rs1_s});
            check_word({tag, " rs2_s"}, {27'b0, a2}, {27'b0, rs2_s});
            check_word({tag, " pc"}, h.pc, pc_out);
            check_word({tag, " pc_next"}, h.pc + 32'd4, pc_next);
            check_preg({tag, " ps1"}, map_m[a1], ps1);
            check_preg({tag, " ps2"}, map_m[a2], ps2);
            check_flag({tag, " ps1_ready"},
                       ready_m[a1] || (cdb_valid && cdb_preg == map_m[a1]), ps1_ready);
            check_flag({tag, " ps2_ready"},
                       ready_m[a2] || (cdb_valid && cdb_preg == map_m[a2]), ps2_ready);
            if (!h.need)
                check_preg({tag, " pd"}, '0, pd);
            else if (fl_q.size() > 0)
                check_preg({tag, " pd"}, fl_q[0], pd);
        end
        if (cdb_valid) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                if (map_m[i] == cdb_preg) ready_m[i] = 1'b1;
            end
        end
        // a fresh mapping is not ready even if broadcast this cycle
        if (exp_disp) begin
            void'(iq_q.pop_front());
            if (h.need) begin
                map_m[ad] = fl_q.pop_front();
                ready_m[ad] = 1'b0;
            end
        end
        if (release_valid) fl_q.push_back(release_preg);
        if (accepted) iq_q.push_back(r);
    endtask

    task automatic drive(input logic do_push, input row_t r, input logic [5:0] lv,
                         input logic cv, input phys_reg_t cp,
                         input logic rv, input phys_reg_t rp);
        @(posedge clk);
        push <= do_push;
        inst <= r.inst;
        pc <= r.pc;
        {rob_full, rs_full_alu, rs_full_mul, rs_full_div, rs_full_br, rs_full_mem} <= lv;
        cdb_valid <= cv;
        cdb_preg <= cp;
        release_valid <= rv;
        release_preg <= rp;
        @(negedge clk);
        check_and_update(do_push, r);
    endtask

    // push one row, hold its stall levels for three cycles, wait until it leaves
    task automatic run_row(input row_t r, input int release_at, input logic rand_cdb);
        int k;
        phys_reg_t cp;
        logic [5:0] lv;
        row_t idle;
        idle = '0;
        k = 0;
        drive(1'b1, r, r.stall, 1'b0, '0, 1'b0, '0);
        while (iq_q.size() > 0) begin
            k++;
            lcg_state = lcg_next(lcg_state);
            lv = (k <= 3) ? r.stall : 6'b0;
            cp = lcg_state[20] ? map_m[r.inst[24:20]] : map_m[r.inst[19:15]];
            drive(1'b0, idle, lv, rand_cdb && lcg_state[16], cp,
                  k == release_at, phys_reg_t'(40));
        end
    endtask

    initial begin
        row_t r;
        row_t idle;
        clk = 1'b0;
        rst = 1'b1;
        push = 1'b0;
        inst = '0;
        pc = '0;
        rob_full = 1'b0;
        rs_full_alu = 1'b0;
        rs_full_mul = 1'b0;
        rs_full_div = 1'b0;
        rs_full_br = 1'b0;
        rs_full_mem = 1'b0;
        release_valid = 1'b0;
        release_preg = '0;
        cdb_valid = 1'b0;
        cdb_preg = '0;
        cycles = 0;
        idle = '0;
        lcg_state = 32'd86963;
        next_pc = 32'h0000_2000;
        for (int i = 0; i < ARCH_REGS; i++) begin
            map_m[i] = phys_reg_t'(i);
            ready_m[i] = 1'b1;
        end
        for (int i = ARCH_REGS; i < PHYS_REGS; i++) fl_q.push_back(phys_reg_t'(i));

        // inst, pc, stall, class, imm, rd, needs rd
        table_rows[0]  = '{32'h00500093, 32'h1000, 6'b000000, RS_ALU, 32'd5, 5'd1, 1'b1};
        table_rows[1]  = '{32'h00108133, 32'h1004, 6'b100000, RS_ALU, 32'd0, 5'd2, 1'b1};
        table_rows[2]  = '{32'h022081B3, 32'h1008, 6'b001000, RS_MUL, 32'd0, 5'd3, 1'b1};
        table_rows[3]  = '{32'h0211C233, 32'h100C, 6'b010000, RS_DIV, 32'd0, 5'd4, 1'b1};
        table_rows[4]  = '{32'h023272B3, 32'h1010, 6'b000000, RS_DIV, 32'd0, 5'd5, 1'b1};
        table_rows[5]  = '{32'hFFC0A303, 32'h1014, 6'b000001, RS_MEM, 32'hFFFFFFFC, 5'd6, 1'b1};
        table_rows[6]  = '{32'h00232423, 32'h1018, 6'b000000, RS_MEM, 32'd8, 5'd8, 1'b0};
        table_rows[7]  = '{32'hFE208CE3, 32'h101C, 6'b000010, RS_BR, 32'hFFFFFFF8, 5'd25, 1'b0};
        table_rows[8]  = '{32'h123453B7, 32'h1020, 6'b000000, RS_ALU, 32'h12345000, 5'd7, 1'b1};
        table_rows[9]  = '{32'hFFFFF417, 32'h1024, 6'b000000, RS_ALU, 32'hFFFFF000, 5'd8, 1'b1};
        table_rows[10] = '{32'h001000EF, 32'h1028, 6'b000000, RS_BR, 32'h00000800, 5'd1, 1'b1};
        table_rows[11] = '{32'h00408067, 32'h102C, 6'b000000, RS_BR, 32'd4, 5'd0, 1'b0};
        table_rows[12] = '{32'h00000013, 32'h1030, 6'b000000, RS_ALU, 32'd0, 5'd0, 1'b0};
        table_rows[13] = '{32'h0283B4B3, 32'h1034, 6'b000100, RS_MUL, 32'd0, 5'd9, 1'b1};

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) run_row(table_rows[i], 0, 1'b1);

        // use up the free list, then a store still goes and addi waits for a release
        while (fl_q.size() > 0) begin
            run_row(make_row(32'h00128313, RS_ALU, 32'd1, 5'd6, 1'b1), 0, 1'b0);
        end
        run_row(make_row(32'h0062A023, RS_MEM, 32'd0, 5'd0, 1'b0), 0, 1'b0);
        run_row(make_row(32'h00130393, RS_ALU, 32'd1, 5'd7, 1'b1), 3, 1'b0);

        // fill the queue behind a full alu station; the ninth push is dropped
        for (int j = 0; j <= IQ_DEPTH; j++) begin
            r = make_row(32'((j + 1) << 20) | 32'h13, RS_ALU, 32'(j + 1), 5'd0, 1'b0);
            drive(1'b1, r, 6'b010000, 1'b0, '0, 1'b0, '0);
        end
        while (iq_q.size() > 0) drive(1'b0, idle, 6'b0, 1'b0, '0, 1'b0, '0);
        repeat (3) drive(1'b0, idle, 6'b0, 1'b0, '0, 1'b0, '0);

        if (UUT.u_asserts.fail_count != 0) begin
            $display("bound assertions failed %0d times", UUT.u_asserts.fail_count);
            $display("=== FAIL ===");
            $fatal(1, "assertion failure");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verif/rename_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module rename_asserts (
    input wire logic clk,
    input wire logic rst,
    input wire logic dispatch,
    input wire logic alloc,
    input wire logic fl_empty,
    input wire logic rob_full
);

    // failures seen so far, read by the testbench
    int fail_count = 0;

    // a preg is only taken by an instruction that leaves
    alloc_needs_dispatch: assert property (@(posedge clk) disable iff (rst)
        alloc |-> dispatch)
        else begin
            $error("alloc without dispatch");
            fail_count++;
        end

    alloc_not_empty: assert property (@(posedge clk) disable iff (rst)
        alloc |-> !fl_empty)
        else begin
            $error("alloc from an empty free list");
            fail_count++;
        end

    no_dispatch_rob_full: assert property (@(posedge clk) disable iff (rst)
        rob_full |-> !dispatch)
        else begin
            $error("dispatch while rob full");
            fail_count++;
        end

    // queue is empty in the first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !dispatch)
        else begin
            $error("dispatch right after reset");
            fail_count++;
        end

endmodule

bind rename_top rename_asserts u_asserts (
    .clk(clk),
    .rst(rst),
    .dispatch(dispatch),
    .alloc(alloc),
    .fl_empty(fl_empty),
    .rob_full(rob_full)
);

`default_nettype wire

// File: hdl/rename_top.sv
`timescale 1ns/1ns
`default_nettype none

module rename_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   push,
    input  wire logic [31:0]            inst,
    input  wire logic [31:0]            pc,
    output logic                        iq_full,
    input  wire logic                   rob_full,
    input  wire logic                   rs_full_alu,
    input  wire logic                   rs_full_mul,
    input  wire logic                   rs_full_div,
    input  wire logic                   rs_full_br,
    input  wire logic                   rs_full_mem,
    input  wire logic                   release_valid,
    input  wire ooo_cfg_pkg::phys_reg_t release_preg,
    input  wire logic                   cdb_valid,
    input  wire ooo_cfg_pkg::phys_reg_t cdb_preg,
    output logic                        dispatch,
    output ooo_cfg_pkg::rs_sel_e        rs_sel,
    output rv32i_types::opcode_e        opcode,
    output logic [2:0]                  funct3,
    output logic [6:0]                  funct7,
    output ooo_cfg_pkg::arch_reg_t      rd_s,
    output ooo_cfg_pkg::arch_reg_t      rs1_s,
    output ooo_cfg_pkg::arch_reg_t      rs2_s,
    output logic [31:0]                 imm,
    output logic [31:0]                 pc_out,
    output logic [31:0]                 pc_next,
    output ooo_cfg_pkg::phys_reg_t      pd,
    output ooo_cfg_pkg::phys_reg_t      ps1,
    output ooo_cfg_pkg::phys_reg_t      ps2,
    output logic                        ps1_ready,
    output logic                        ps2_ready
);
    import ooo_cfg_pkg::*;

    logic head_valid;
    logic [31:0] head_inst;
    logic [31:0] head_pc;
    logic pop;
    logic fl_empty;
    phys_reg_t fl_head;
    logic alloc;
    logic rat_we;
    arch_reg_t rat_rs1;
    arch_reg_t rat_rs2;
    arch_reg_t rat_rd;
    phys_reg_t rat_ps1;
    phys_reg_t rat_ps2;
    logic rat_ps1_ready;
    logic rat_ps2_ready;

    inst_queue u_iq (
        .clk(clk), .rst(rst), .push(push), .inst(inst), .pc(pc), .pop(pop),
        .head_valid(head_valid), .head_inst(head_inst), .head_pc(head_pc),
        .full(iq_full)
    );

    free_list u_fl (
        .clk(clk), .rst(rst), .alloc(alloc), .release_valid(release_valid),
        .release_preg(release_preg), .empty(fl_empty), .head(fl_head)
    );

    rat u_rat (
        .clk(clk), .rst(rst), .rs1(rat_rs1), .rs2(rat_rs2),
        .ps1(rat_ps1), .ps2(rat_ps2), .ps1_ready(rat_ps1_ready), .ps2_ready(rat_ps2_ready),
        .we(rat_we), .rd(rat_rd), .pd(pd), .cdb_valid(cdb_valid), .cdb_preg(cdb_preg)
    );

    rename_dispatch u_rd (
        .head_valid(head_valid), .head_inst(head_inst), .head_pc(head_pc),
        .rob_full(rob_full), .rs_full_alu(rs_full_alu), .rs_full_mul(rs_full_mul),
        .rs_full_div(rs_full_div), .rs_full_br(rs_full_br), .rs_full_mem(rs_full_mem),
        .fl_empty(fl_empty), .fl_head(fl_head),
        .ps1_in(rat_ps1), .ps2_in(rat_ps2),
        .ps1_ready_in(rat_ps1_ready), .ps2_ready_in(rat_ps2_ready),
        .pop(pop), .alloc(alloc), .rat_we(rat_we),
        .rat_rs1(rat_rs1), .rat_rs2(rat_rs2), .rat_rd(rat_rd),
        .dispatch(dispatch), .rs_sel(rs_sel), .opcode(opcode),
        .funct3(funct3), .funct7(funct7),
        .rd_s(rd_s), .rs1_s(rs1_s), .rs2_s(rs2_s), .imm(imm),
        .pc(pc_out), .pc_next(pc_next), .pd(pd), .ps1(ps1), .ps2(ps2),
        .ps1_ready(ps1_ready), .ps2_ready(ps2_ready)
    );

endmodule

`default_nettype wire

// File: hdl/rename_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module rename_dispatch (
    input  wire logic                   head_valid,
    input  wire logic [31:0]            head_inst,
    input  wire logic [31:0]            head_pc,
    input  wire logic                   rob_full,
    input  wire logic                   rs_full_alu,
    input  wire logic                   rs_full_mul,
    input  wire logic                   rs_full_div,
    input  wire logic                   rs_full_br,
    input  wire logic                   rs_full_mem,
    input  wire logic                   fl_empty,
    input  wire ooo_cfg_pkg::phys_reg_t fl_head,
    input  wire ooo_cfg_pkg::phys_reg_t ps1_in,
    input  wire ooo_cfg_pkg::phys_reg_t ps2_in,
    input  wire logic                   ps1_ready_in,
    input  wire logic                   ps2_ready_in,
    output logic                        pop,
    output logic                        alloc,
    output logic                        rat_we,
    output ooo_cfg_pkg::arch_reg_t      rat_rs1,
    output ooo_cfg_pkg::arch_reg_t      rat_rs2,
    output ooo_cfg_pkg::arch_reg_t      rat_rd,
    output logic                        dispatch,
    output ooo_cfg_pkg::rs_sel_e        rs_sel,
    output rv32i_types::opcode_e        opcode,
    output logic [2:0]                  funct3,
    output logic [6:0]                  funct7,
    output ooo_cfg_pkg::arch_reg_t      rd_s,
    output ooo_cfg_pkg::arch_reg_t      rs1_s,
    output ooo_cfg_pkg::arch_reg_t      rs2_s,
    output logic [31:0]                 imm,
    output logic [31:0]                 pc,
    output logic [31:0]                 pc_next,
    output ooo_cfg_pkg::phys_reg_t      pd,
    output ooo_cfg_pkg::phys_reg_t      ps1,
    output ooo_cfg_pkg::phys_reg_t      ps2,
    output logic                        ps1_ready,
    output logic                        ps2_ready
);
    import ooo_cfg_pkg::*;
    import rv32i_types::*;

    imm_fmt_e fmt;
    md_funct3_e md_op;
    logic class_full;
    logic needs_rd;

    // field extraction
    assign opcode = opcode_e'(head_inst[6:0]);
    assign funct3 = head_inst[14:12];
    assign funct7 = head_inst[31:25];
    assign rd_s = head_inst[11:7];
    assign rs1_s = head_inst[19:15];
    assign rs2_s = head_inst[24:20];
    assign md_op = md_funct3_e'(funct3);
    assign pc = head_pc;
    // no prediction, fall through only
    assign pc_next = head_pc + 32'd4;

    always_comb begin
        rs_sel = RS_ALU;
        case (opcode)
            OP_REG: begin
                if (funct7 == MD_FUNCT7) begin
                    case (md_op)
                        MUL, MULH, MULHSU, MULHU: rs_sel = RS_MUL;
                        DIV, DIVU, REM, REMU:     rs_sel = RS_DIV;
                    endcase
                end
            end
            OP_JAL, OP_JALR, OP_BR: rs_sel = RS_BR;
            OP_LOAD, OP_STORE:      rs_sel = RS_MEM;
            default:                rs_sel = RS_ALU;
        endcase
    end

    // only the head's own station can hold it back
    always_comb begin
        case (rs_sel)
            RS_ALU:  class_full = rs_full_alu;
            RS_MUL:  class_full = rs_full_mul;
            RS_DIV:  class_full = rs_full_div;
            RS_BR:   class_full = rs_full_br;
            RS_MEM:  class_full = rs_full_mem;
            default: class_full = 1'b1;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_IMM, OP_LOAD, OP_JALR: fmt = FMT_I;
            OP_STORE:                 fmt = FMT_S;
            OP_BR:                    fmt = FMT_B;
            OP_LUI, OP_AUIPC:         fmt = FMT_U;
            OP_JAL:                   fmt = FMT_J;
            default:                  fmt = FMT_R;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I:   imm = {{21{head_inst[31]}}, head_inst[30:20]};
            FMT_S:   imm = {{21{head_inst[31]}}, head_inst[30:25], head_inst[11:7]};
            FMT_B:   imm = {{20{head_inst[31]}}, head_inst[7], head_inst[30:25],
                            head_inst[11:8], 1'b0};
            FMT_U:   imm = {head_inst[31:12], 12'h000};
            FMT_J:   imm = {{12{head_inst[31]}}, head_inst[19:12], head_inst[20],
                            head_inst[30:21], 1'b0};
            default: imm = 32'd0;
        endcase
    end

    // branches, stores and writes to x0 take no preg
    assign needs_rd = !((opcode == OP_BR) || (opcode == OP_STORE) || (rd_s == '0));

    assign dispatch = head_valid && !rob_full && !class_full && (!needs_rd || !fl_empty);
    assign pop = dispatch;
    assign alloc = dispatch && needs_rd;
    assign rat_we = alloc;

    // rename lookups
    assign rat_rs1 = rs1_s;
    assign rat_rs2 = rs2_s;
    assign rat_rd = rd_s;
    assign pd = needs_rd ? fl_head : '0;
    assign ps1 = ps1_in;
    assign ps2 = ps2_in;
    assign ps1_ready = ps1_ready_in;
    assign ps2_ready = ps2_ready_in;

endmodule

`default_nettype wire

// File: hdl/rat.sv
`timescale 1ns/1ns
`default_nettype none

module rat (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire ooo_cfg_pkg::arch_reg_t rs1,
    input  wire ooo_cfg_pkg::arch_reg_t rs2,
    output ooo_cfg_pkg::phys_reg_t      ps1,
    output ooo_cfg_pkg::phys_reg_t      ps2,
    output logic                        ps1_ready,
    output logic                        ps2_ready,
    input  wire logic                   we,
    input  wire ooo_cfg_pkg::arch_reg_t rd,
    input  wire ooo_cfg_pkg::phys_reg_t pd,
    input  wire logic                   cdb_valid,
    input  wire ooo_cfg_pkg::phys_reg_t cdb_preg
);
    import ooo_cfg_pkg::*;

    phys_reg_t map [ARCH_REGS];
    logic [ARCH_REGS-1:0] ready;

    // reads see a same-cycle broadcast
    assign ps1 = map[rs1];
    assign ps2 = map[rs2];
    assign ps1_ready = ready[rs1] || (cdb_valid && (cdb_preg == map[rs1]));
    assign ps2_ready = ready[rs2] || (cdb_valid && (cdb_preg == map[rs2]));

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= phys_reg_t'(i);
            end
            ready <= '1;
        end else begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                if (cdb_valid && (map[i] == cdb_preg)) ready[i] <= 1'b1;
            end
            // new mapping wins over a broadcast of the same preg
            // x0 keeps preg 0 and stays ready
            if (we && (rd != '0)) begin
                map[rd] <= pd;
                ready[rd] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/free_list.sv
`timescale 1ns/1ns
`default_nettype none

module free_list (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  alloc,
    input  wire logic                  release_valid,
    input  wire ooo_cfg_pkg::phys_reg_t release_preg,
    output logic                       empty,
    output ooo_cfg_pkg::phys_reg_t     head
);
    import ooo_cfg_pkg::*;

    phys_reg_t fl_mem [FL_DEPTH];
    logic [FL_PTR_BITS-1:0] head_ptr;
    logic [FL_PTR_BITS-1:0] tail_ptr;
    logic [FL_CNT_BITS-1:0] count;
    logic do_alloc;
    logic do_release;

    assign empty = (count == '0);
    assign head = fl_mem[head_ptr];
    assign do_alloc = alloc && !empty;
    // a full list still takes a release when the head frees a slot this cycle
    assign do_release = release_valid &&
                        ((count != FL_CNT_BITS'(FL_DEPTH)) || do_alloc);

    always_ff @(posedge clk) begin
        if (rst) begin
            // pregs above the identity map start out free, lowest first
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= phys_reg_t'(ARCH_REGS + i);
            end
            head_ptr <= '0;
            tail_ptr <= '0;
            count <= FL_CNT_BITS'(FL_DEPTH);
        end else begin
            if (do_alloc) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (do_release) begin
                fl_mem[tail_ptr] <= release_preg;
                tail_ptr <= tail_ptr + 1'b1;
            end
            count <= count + FL_CNT_BITS'(do_release) - FL_CNT_BITS'(do_alloc);
        end
    end

endmodule

`default_nettype wire

// File: hdl/inst_queue.sv
`timescale 1ns/1ns
`default_nettype none

module inst_queue (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        push,
    input  wire logic [31:0] inst,
    input  wire logic [31:0] pc,
    input  wire logic        pop,
    output logic             head_valid,
    output logic [31:0]      head_inst,
    output logic [31:0]      head_pc,
    output logic             full
);
    import ooo_cfg_pkg::*;

    logic [31:0] inst_mem [IQ_DEPTH];
    logic [31:0] pc_mem [IQ_DEPTH];
    logic [IQ_PTR_BITS-1:0] rd_ptr;
    logic [IQ_PTR_BITS-1:0] wr_ptr;
    logic [IQ_CNT_BITS-1:0] count;
    logic do_push;
    logic do_pop;

    // flags stay combinational so pop sees the live count
    assign full = (count == IQ_CNT_BITS'(IQ_DEPTH));
    assign head_valid = (count != '0);
    assign do_push = push && !full;
    assign do_pop = pop && head_valid;

    assign head_inst = inst_mem[rd_ptr];
    assign head_pc = pc_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            // pointers wrap naturally, depth is a power of two
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + IQ_CNT_BITS'(do_push) - IQ_CNT_BITS'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            inst_mem[wr_ptr] <= inst;
            pc_mem[wr_ptr] <= pc;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv32i_types.sv
`default_nettype none

package rv32i_types;

    // base opcodes in inst[6:0]
    typedef enum logic [6:0] {
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_JAL   = 7'b1101111,
        OP_JALR  = 7'b1100111,
        OP_BR    = 7'b1100011,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011,
        OP_IMM   = 7'b0010011,
        OP_REG   = 7'b0110011
    } opcode_e;

    // rv32m function codes, only meaningful together with MD_FUNCT7
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } md_funct3_e;

    // funct7 of every mul/div instruction
    localparam logic [6:0] MD_FUNCT7 = 7'b0000001;

    // immediate encodings
    // FMT_R covers register-register ops, which carry no immediate
    typedef enum logic [2:0] {
        FMT_R = 3'd0,
        FMT_I = 3'd1,
        FMT_S = 3'd2,
        FMT_B = 3'd3,
        FMT_U = 3'd4,
        FMT_J = 3'd5
    } imm_fmt_e;

endpackage

`default_nettype wire

// File: hdl/ooo_cfg_pkg.sv
`default_nettype none

package ooo_cfg_pkg;

    // register file sizes
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    // instruction queue sizing
    localparam int IQ_DEPTH = 8;
    localparam int IQ_PTR_BITS = $clog2(IQ_DEPTH);
    localparam int IQ_CNT_BITS = IQ_PTR_BITS + 1;

    // free list holds every preg not mapped at reset
    localparam int FL_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int FL_PTR_BITS = $clog2(FL_DEPTH);
    localparam int FL_CNT_BITS = FL_PTR_BITS + 1;

    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;

    // reservation station classes
    typedef enum logic [2:0] {
        RS_ALU = 3'b000,
        RS_MUL = 3'b001,
        RS_DIV = 3'b010,
        RS_BR  = 3'b011,
        RS_MEM = 3'b100
    } rs_sel_e;

endpackage

`default_nettype wire
